// File: verilog/music_pkg.sv
package music_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    localparam int NUM_VOICES = 4;
    localparam int SAMPLE_W   = 16;
    // Four voices at this peak still fit in SAMPLE_W
    localparam int VOICE_AMP  = 8191;
    localparam int PHASE_W    = 20;
    localparam int NUM_SONGS  = 2;
    localparam int SONG_LEN   = 16;
    // Mixer FIFO depth, also the starting credit count of each voice
    localparam int BUF_DEPTH  = 2;

    localparam int VOICE_W    = $clog2(NUM_VOICES);
    localparam int SONG_W     = $clog2(NUM_SONGS);
    localparam int ENTRY_W    = $clog2(SONG_LEN);
    localparam int STEP_W     = 16;
    localparam int BEATS_W    = 4;
    localparam int SINE_IDX_W = 4;
    localparam int PTR_W      = $clog2(BUF_DEPTH);
    // Wide enough to hold 0..BUF_DEPTH
    localparam int CNT_W      = $clog2(BUF_DEPTH + 1);

    // ==========================================================
    // Types
    // ==========================================================
    typedef enum logic [1:0] {OP_NOTE, OP_WAIT, OP_END} op_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_PLAY, SEQ_WAIT, SEQ_PAUSE} seq_state_t;

    typedef struct packed {
        op_t                opcode;
        logic [VOICE_W-1:0] voice;
        logic [STEP_W-1:0]  step;
        logic [BEATS_W-1:0] beats;
    } song_entry_t;

    typedef struct packed {
        logic               start;
        logic [STEP_W-1:0]  step;
        logic [BEATS_W-1:0] beats;
    } note_cmd_t;

    typedef struct packed {
        logic                       valid;
        logic signed [SAMPLE_W-1:0] sample;
    } voice_sample_t;

    // ==========================================================
    // Song book, steps assume a 48 kHz frame rate
    // ==========================================================
    localparam song_entry_t SONG_BOOK [NUM_SONGS][SONG_LEN] = '{
        // Song 0, C major chords
        '{
            '{OP_NOTE, 2'd0, 16'd5715, 4'd8}, '{OP_NOTE, 2'd1, 16'd7201, 4'd8},
            '{OP_NOTE, 2'd2, 16'd8563, 4'd8}, '{OP_WAIT, 2'd0, 16'd0, 4'd4},
            '{OP_NOTE, 2'd3, 16'd11430, 4'd4}, '{OP_WAIT, 2'd0, 16'd0, 4'd4},
            '{OP_NOTE, 2'd0, 16'd7629, 4'd6}, '{OP_NOTE, 2'd1, 16'd9612, 4'd6},
            '{OP_NOTE, 2'd2, 16'd11430, 4'd6}, '{OP_WAIT, 2'd0, 16'd0, 4'd6},
            '{OP_NOTE, 2'd0, 16'd8563, 4'd4}, '{OP_NOTE, 2'd1, 16'd10789, 4'd4},
            '{OP_NOTE, 2'd2, 16'd6415, 4'd4}, '{OP_WAIT, 2'd0, 16'd0, 4'd4},
            '{OP_WAIT, 2'd0, 16'd0, 4'd2}, '{OP_END, 2'd0, 16'd0, 4'd0}
        },
        // Song 1, A minor arpeggio
        '{
            '{OP_NOTE, 2'd0, 16'd9612, 4'd4}, '{OP_WAIT, 2'd0, 16'd0, 4'd2},
            '{OP_NOTE, 2'd1, 16'd11430, 4'd4}, '{OP_WAIT, 2'd0, 16'd0, 4'd2},
            '{OP_NOTE, 2'd2, 16'd7201, 4'd6}, '{OP_NOTE, 2'd3, 16'd9612, 4'd6},
            '{OP_WAIT, 2'd0, 16'd0, 4'd6}, '{OP_NOTE, 2'd0, 16'd6415, 4'd3},
            '{OP_WAIT, 2'd0, 16'd0, 4'd3}, '{OP_NOTE, 2'd1, 16'd7629, 4'd3},
            '{OP_WAIT, 2'd0, 16'd0, 4'd3}, '{OP_NOTE, 2'd2, 16'd9612, 4'd5},
            '{OP_NOTE, 2'd3, 16'd6415, 4'd5}, '{OP_WAIT, 2'd0, 16'd0, 4'd5},
            '{OP_END, 2'd0, 16'd0, 4'd0}, '{OP_END, 2'd0, 16'd0, 4'd0}
        }
    };

    // Quarter wave sampled at half-step offsets, so mirroring needs no extra point
    localparam logic signed [SAMPLE_W-1:0] SINE_QUARTER [2**SINE_IDX_W] = '{
        16'sd402,  16'sd1202, 16'sd1990, 16'sd2759,
        16'sd3502, 16'sd4211, 16'sd4879, 16'sd5501,
        16'sd6069, 16'sd6579, 16'sd7026, 16'sd7405,
        16'sd7712, 16'sd7945, 16'sd8102, 16'sd8181
    };

endpackage

// File: verilog/button_press_unit.sv
`timescale 1ns/1ps

module button_press_unit #(
    parameter int WIDTH = 20
) (
    input  logic clk_100,
    input  logic arst_n,
    input  logic button,
    output logic press
);

    // Two-flop synchronizer
    logic [1:0]       sync;
    // Debounced level and its hold counter
    logic             stable;
    logic [WIDTH-1:0] count;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            sync   <= '0;
            stable <= 1'b0;
            count  <= '0;
            press  <= 1'b0;
        end else begin
            sync  <= {sync[0], button};
            press <= 1'b0;
            if (sync[1] == stable) begin
                // Input agrees with the debounced level, restart hold time
                count <= '0;
            end else if (&count) begin
                // Held long enough, accept new level
                stable <= sync[1];
                count  <= '0;
                // Pulse only on the press edge
                press  <= sync[1];
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: verilog/note_sequencer.sv
`timescale 1ns/1ps

module note_sequencer
    import music_pkg::*;
#(
    parameter int BEAT_COUNT = 1000
) (
    input  logic              clk_100,
    input  logic              arst_n,
    input  logic              play_press,
    input  logic              next_press,
    output note_cmd_t         note_cmd [NUM_VOICES],
    output logic              beat_tick,
    output logic              run,
    output logic              playing,
    output logic [SONG_W-1:0] song_index
);

    localparam int BEAT_W = $clog2(BEAT_COUNT + 1);

    seq_state_t             state;
    // State to go back to when leaving pause
    seq_state_t             resume_state;
    logic [ENTRY_W-1:0]     entry_idx;
    logic [BEATS_W-1:0]     wait_cnt;
    logic [BEAT_W-1:0]      beat_cnt;
    song_entry_t            entry;
    // Start flags per voice, payload shared by all voices
    logic [NUM_VOICES-1:0]  cmd_start;
    logic [STEP_W-1:0]      cmd_step;
    logic [BEATS_W-1:0]     cmd_beats;

    assign entry     = SONG_BOOK[song_index][entry_idx];
    assign run       = (state == SEQ_PLAY) || (state == SEQ_WAIT);
    assign playing   = run;
    assign beat_tick = run && (beat_cnt == BEAT_W'(BEAT_COUNT - 1));

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_cmd
        assign note_cmd[v] = '{start: cmd_start[v], step: cmd_step, beats: cmd_beats};
    end

    // ==========================================================
    // Beat timer, frozen while paused
    // ==========================================================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (state == SEQ_IDLE) begin
            beat_cnt <= '0;
        end else if (run) begin
            beat_cnt <= beat_tick ? '0 : beat_cnt + 1'b1;
        end
    end

    // ==========================================================
    // Song walker
    // ==========================================================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state        <= SEQ_IDLE;
            resume_state <= SEQ_PLAY;
            entry_idx    <= '0;
            wait_cnt     <= '0;
            song_index   <= '0;
            cmd_start    <= '0;
        end else begin
            cmd_start <= '0;
            if (next_press) begin
                // Next song from the top, play or pause kept
                song_index <= (song_index == SONG_W'(NUM_SONGS - 1)) ? '0 : song_index + 1'b1;
                entry_idx  <= '0;
                if (state == SEQ_WAIT) state <= SEQ_PLAY;
                if (state == SEQ_PAUSE) resume_state <= SEQ_PLAY;
            end else if (play_press) begin
                case (state)
                    SEQ_IDLE: begin
                        state     <= SEQ_PLAY;
                        entry_idx <= '0;
                    end
                    SEQ_PAUSE: state <= resume_state;
                    default: begin
                        resume_state <= state;
                        state        <= SEQ_PAUSE;
                    end
                endcase
            end else if (state == SEQ_PLAY) begin
                case (entry.opcode)
                    OP_NOTE: begin
                        cmd_start[entry.voice] <= 1'b1;
                        entry_idx              <= entry_idx + 1'b1;
                    end
                    OP_WAIT: begin
                        wait_cnt <= entry.beats;
                        state    <= SEQ_WAIT;
                    end
                    default: begin
                        // End of song, rewind for the next play
                        state     <= SEQ_IDLE;
                        entry_idx <= '0;
                    end
                endcase
            end else if (state == SEQ_WAIT && beat_tick) begin
                // Zero-beat waits leave on the first tick
                if (wait_cnt <= BEATS_W'(1)) begin
                    state     <= SEQ_PLAY;
                    entry_idx <= entry_idx + 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

    // Note payload, only meaningful with a start flag
    always_ff @(posedge clk_100) begin
        cmd_step  <= entry.step;
        cmd_beats <= entry.beats;
    end

endmodule

// File: verilog/note_player.sv
`timescale 1ns/1ps

module note_player
    import music_pkg::*;
(
    input  logic          clk_100,
    input  logic          arst_n,
    input  note_cmd_t     cmd,
    input  logic          beat_tick,
    input  logic          run,
    input  logic          credit_return,
    output voice_sample_t voice_out
);

    logic [PHASE_W-1:0]         phase;
    logic [STEP_W-1:0]          step;
    logic [BEATS_W-1:0]         remaining;
    logic [CNT_W-1:0]           credits;
    logic                       sounding;
    logic                       emit;
    logic [1:0]                 quadrant;
    logic [SINE_IDX_W-1:0]      tbl_idx;
    logic signed [SAMPLE_W-1:0] mag;
    logic signed [SAMPLE_W-1:0] sine;

    assign sounding = (remaining != '0);
    // One sample per held credit
    assign emit     = (credits != '0);

    // ==========================================================
    // Quarter-wave lookup
    // ==========================================================
    always_comb begin
        quadrant = phase[PHASE_W-1 -: 2];
        tbl_idx  = phase[PHASE_W-3 -: SINE_IDX_W];
        // Odd quadrants run the table backwards
        if (quadrant[0]) tbl_idx = ~tbl_idx;
        mag  = SINE_QUARTER[tbl_idx];
        // Lower half of the wave
        sine = quadrant[1] ? -mag : mag;
    end

    // ==========================================================
    // Duration, credits and sample output
    // ==========================================================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
            credits   <= CNT_W'(BUF_DEPTH);
            voice_out <= '0;
        end else begin
            if (cmd.start) begin
                remaining <= cmd.beats;
            end else if (beat_tick && run && sounding) begin
                remaining <= remaining - 1'b1;
            end
            case ({emit, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            voice_out.valid  <= emit;
            voice_out.sample <= (emit && run && sounding) ? sine : '0;
        end
    end

    // Phase only moves for samples that carry the tone
    always_ff @(posedge clk_100) begin
        if (cmd.start) begin
            phase <= '0;
            step  <= cmd.step;
        end else if (emit && run && sounding) begin
            phase <= phase + PHASE_W'(step);
        end
    end

endmodule

// File: verilog/sample_mixer.sv
`timescale 1ns/1ps

module sample_mixer
    import music_pkg::*;
(
    input  logic                       clk_100,
    input  logic                       arst_n,
    input  voice_sample_t              voice_in [NUM_VOICES],
    input  logic                       new_frame,
    output logic [NUM_VOICES-1:0]      credit_return,
    output logic signed [SAMPLE_W-1:0] sample_out,
    output logic                       new_sample
);

    // Per-voice FIFO storage and pointers
    logic signed [SAMPLE_W-1:0] fifo_mem [NUM_VOICES][BUF_DEPTH];
    logic [PTR_W-1:0]           wr_ptr [NUM_VOICES];
    logic [PTR_W-1:0]           rd_ptr [NUM_VOICES];
    logic [CNT_W-1:0]           fill [NUM_VOICES];
    logic [NUM_VOICES-1:0]      not_empty;
    logic                       pop;
    // Adder stage
    logic signed [SAMPLE_W-1:0] head_sum;
    logic signed [SAMPLE_W-1:0] sum_q;
    logic                       sum_valid;

    // Frame is skipped unless every voice has a sample waiting
    assign pop = new_frame && (&not_empty);

    always_comb begin
        head_sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            not_empty[v] = (fill[v] != '0);
            // Fits SAMPLE_W, peak is NUM_VOICES * VOICE_AMP
            head_sum     = head_sum + fifo_mem[v][rd_ptr[v]];
        end
    end

    // ==========================================================
    // FIFO control, samples delivered lag the voices by two frames
    // ==========================================================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                fill[v]   <= '0;
            end
            credit_return <= '0;
            sum_valid     <= 1'b0;
            new_sample    <= 1'b0;
            sample_out    <= '0;
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (voice_in[v].valid) begin
                    wr_ptr[v] <= (wr_ptr[v] == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr[v] + 1'b1;
                end
                if (pop) begin
                    rd_ptr[v] <= (rd_ptr[v] == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr[v] + 1'b1;
                end
                fill[v] <= fill[v] + CNT_W'(voice_in[v].valid) - CNT_W'(pop);
            end
            // Each pop hands one credit back to every voice
            credit_return <= {NUM_VOICES{pop}};
            sum_valid     <= pop;
            new_sample    <= sum_valid;
            if (sum_valid) sample_out <= sum_q;
        end
    end

    always_ff @(posedge clk_100) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (voice_in[v].valid) fifo_mem[v][wr_ptr[v]] <= voice_in[v].sample;
        end
        if (pop) sum_q <= head_sum;
    end

endmodule

// File: verilog/music_player.sv
`timescale 1ns/1ps

module music_player
    import music_pkg::*;
#(
    parameter int BPU_WIDTH  = 20,
    parameter int BEAT_COUNT = 1000
) (
    input  logic                       clk_100,
    input  logic                       arst_n,
    input  logic                       play_button,
    input  logic                       next_button,
    input  logic                       new_frame,
    output logic signed [SAMPLE_W-1:0] sample_out,
    output logic                       new_sample,
    output logic                       playing,
    output logic [SONG_W-1:0]          song_index
);

    logic                  play_press;
    logic                  next_press;
    note_cmd_t             note_cmd [NUM_VOICES];
    logic                  beat_tick;
    logic                  run;
    voice_sample_t         voice_out [NUM_VOICES];
    logic [NUM_VOICES-1:0] credit_return;

    // ==========================================================
    // Buttons
    // ==========================================================
    button_press_unit #(.WIDTH(BPU_WIDTH)) i_play_bpu (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .button  (play_button),
        .press   (play_press)
    );

    button_press_unit #(.WIDTH(BPU_WIDTH)) i_next_bpu (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .button  (next_button),
        .press   (next_press)
    );

    // ==========================================================
    // Sequencer, voices and mixer
    // ==========================================================
    note_sequencer #(.BEAT_COUNT(BEAT_COUNT)) i_note_sequencer (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .play_press (play_press),
        .next_press (next_press),
        .note_cmd   (note_cmd),
        .beat_tick  (beat_tick),
        .run        (run),
        .playing    (playing),
        .song_index (song_index)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        note_player i_note_player (
            .clk_100       (clk_100),
            .arst_n        (arst_n),
            .cmd           (note_cmd[v]),
            .beat_tick     (beat_tick),
            .run           (run),
            .credit_return (credit_return[v]),
            .voice_out     (voice_out[v])
        );
    end

    sample_mixer i_sample_mixer (
        .clk_100       (clk_100),
        .arst_n        (arst_n),
        .voice_in      (voice_out),
        .new_frame     (new_frame),
        .credit_return (credit_return),
        .sample_out    (sample_out),
        .new_sample    (new_sample)
    );

endmodule

// File: tests/music_player_properties.sv
`timescale 1ns/1ps

module music_player_properties
    import music_pkg::*;
(
    input logic                       clk_100,
    input logic                       arst_n,
    input logic                       play_press,
    input logic                       next_press,
    input logic                       new_frame,
    input logic                       new_sample,
    input logic signed [SAMPLE_W-1:0] sample_out,
    input logic                       playing,
    input logic [SONG_W-1:0]          song_index
);

    // Voice sample to new_sample spans up to two frames plus the adder stages
    localparam int QUIET_CYCLES = 40;

    // Failure count, polled by the testbench
    int   error_count = 0;
    logic pressed;
    int   quiet_cnt;

    // ==========================================================
    // Observers
    // ==========================================================
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            pressed   <= 1'b0;
            quiet_cnt <= QUIET_CYCLES;
        end else begin
            pressed <= pressed | play_press | next_press;
            // Cycles since playing was last high, saturating
            if (playing) begin
                quiet_cnt <= 0;
            end else if (quiet_cnt < QUIET_CYCLES) begin
                quiet_cnt <= quiet_cnt + 1;
            end
        end
    end

    // ==========================================================
    // Assertions
    // ==========================================================
    a_idle_until_press: assert property (@(posedge clk_100) disable iff (!arst_n)
        !pressed |-> (!playing && song_index == '0 && sample_out == '0))
        else begin error_count++; $error("%0t: output not idle before any press", $time); end

    a_frame_to_sample: assert property (@(posedge clk_100) disable iff (!arst_n)
        new_frame |-> ##2 new_sample)
        else begin error_count++; $error("%0t: no new_sample two cycles after new_frame", $time); end

    a_sample_after_frame: assert property (@(posedge clk_100) disable iff (!arst_n)
        new_sample |-> $past(new_frame, 2))
        else begin error_count++; $error("%0t: new_sample without new_frame", $time); end

    a_quiet_when_stopped: assert property (@(posedge clk_100) disable iff (!arst_n)
        (new_sample && quiet_cnt >= QUIET_CYCLES) |-> sample_out == '0)
        else begin error_count++; $error("%0t: sample %0d while stopped", $time, sample_out); end

    a_magnitude: assert property (@(posedge clk_100) disable iff (!arst_n)
        new_sample |-> (int'(sample_out) <= NUM_VOICES * VOICE_AMP
                        && int'(sample_out) >= -(NUM_VOICES * VOICE_AMP)))
        else begin error_count++; $error("%0t: sample %0d out of range", $time, sample_out); end

    a_play_toggles: assert property (@(posedge clk_100) disable iff (!arst_n)
        (play_press && !next_press) |=> playing != $past(playing))
        else begin error_count++; $error("%0t: play press left playing at %0b", $time, playing); end

    a_next_advances: assert property (@(posedge clk_100) disable iff (!arst_n)
        next_press |=> (int'(song_index) == (int'($past(song_index)) + 1) % NUM_SONGS
                        && playing == $past(playing)))
        else begin error_count++; $error("%0t: next press gave song %0d", $time, song_index); end

endmodule

bind music_player music_player_properties i_music_player_properties (
    .clk_100    (clk_100),
    .arst_n     (arst_n),
    .play_press (play_press),
    .next_press (next_press),
    .new_frame  (new_frame),
    .new_sample (new_sample),
    .sample_out (sample_out),
    .playing    (playing),
    .song_index (song_index)
);

// File: tests/music_player_tb.sv
`timescale 1ns/1ps

module music_player_tb
    import music_pkg::*;
;

    localparam int BPU_WIDTH      = 2;
    localparam int BEAT_COUNT     = 40;
    localparam int FRAME_CYCLES   = 12;
    localparam int HOLD_CYCLES    = 6;
    // Press pulse lands well inside this window
    localparam int PRESS_LIMIT    = 24;
    localparam int MIN_GAP        = 20;
    localparam int QUIET_FRAMES   = 6;
    // Four songs of 16 entries at 15 beats, plus margin
    localparam int TIMEOUT_CYCLES = 4 * SONG_LEN * 15 * BEAT_COUNT + 1600;

    logic                       clk_100;
    logic                       arst_n;
    logic                       play_button;
    logic                       next_button;
    logic                       new_frame;
    logic signed [SAMPLE_W-1:0] sample_out;
    logic                       new_sample;
    logic                       playing;
    logic [SONG_W-1:0]          song_index;
    int                         cycle_count = 0;
    logic [31:0]                lfsr_state  = 32'h3326_6ffc;

    music_player #(.BPU_WIDTH(BPU_WIDTH), .BEAT_COUNT(BEAT_COUNT)) i_music_player (
        .clk_100     (clk_100),
        .arst_n      (arst_n),
        .play_button (play_button),
        .next_button (next_button),
        .new_frame   (new_frame),
        .sample_out  (sample_out),
        .new_sample  (new_sample),
        .playing     (playing),
        .song_index  (song_index)
    );

    // ==========================================================
    // Helpers
    // ==========================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    // One clock, then settle past the edge
    task automatic advance(input int n);
        repeat (n) @(posedge clk_100);
        #1;
    endtask

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic pause_random();
        int n;
        n = 0;
        for (int b = 0; b < 6; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            n = (n << 1) | int'(lfsr_state[0]);
        end
        advance(MIN_GAP + n);
    endtask

    function automatic int first_note_cycles(input int song);
        int  cycles;
        bit  found;
        cycles = 0;
        found  = 1'b0;
        for (int e = 0; e < SONG_LEN; e++) begin
            if (!found && SONG_BOOK[song][e].opcode == OP_NOTE) begin
                cycles = int'(SONG_BOOK[song][e].beats) * BEAT_COUNT;
                found  = 1'b1;
            end
        end
        return cycles;
    endfunction

    // Wait beats up to OP_END, one cycle per entry on top
    function automatic int song_end_cycles(input int song);
        int beats;
        bit done;
        beats = 0;
        done  = 1'b0;
        for (int e = 0; e < SONG_LEN; e++) begin
            if (SONG_BOOK[song][e].opcode == OP_END) begin
                done = 1'b1;
            end else if (!done && SONG_BOOK[song][e].opcode == OP_WAIT) begin
                beats += int'(SONG_BOOK[song][e].beats);
            end
        end
        return beats * BEAT_COUNT + SONG_LEN;
    endfunction

    // Hold a button and wait for its effect; returns cycles since the change
    task automatic push_button(input bit is_next, output int since_change);
        logic              old_playing;
        logic [SONG_W-1:0] old_index;
        int                seen_at;
        int                i;
        old_playing = playing;
        old_index   = song_index;
        seen_at     = -1;
        i           = 0;
        if (is_next) next_button = 1'b1;
        else play_button = 1'b1;
        while (i < HOLD_CYCLES || (seen_at < 0 && i < PRESS_LIMIT)) begin
            advance(1);
            i++;
            if (i == HOLD_CYCLES) begin
                play_button = 1'b0;
                next_button = 1'b0;
            end
            if (seen_at < 0 && (is_next ? song_index != old_index : playing != old_playing)) begin
                seen_at = i;
            end
        end
        assert (seen_at >= 0)
            else abort_run($sformatf("button press had no effect within %0d cycles", i));
        since_change = i - seen_at;
    endtask

    task automatic catch_tone(input int limit, inout int elapsed);
        bit heard;
        heard = 1'b0;
        while (!heard && elapsed <= limit) begin
            advance(1);
            elapsed++;
            heard = new_sample && (sample_out != '0);
        end
        assert (heard)
            else abort_run($sformatf("** Error at %0t: no tone within %0d cycles", $time, limit));
    endtask

    task automatic watch_song_end(input int bound, input int elapsed);
        while (playing && elapsed <= bound) begin
            advance(1);
            elapsed++;
        end
        assert (!playing)
            else abort_run($sformatf("** Error at %0t: song still playing after %0d cycles",
                                     $time, bound));
    endtask

    // ==========================================================
    // Clock, frames and watchdog
    // ==========================================================
    initial begin
        clk_100 = 1'b0;
        forever #5 clk_100 = ~clk_100;
    end

    initial begin
        new_frame = 1'b0;
        @(posedge arst_n);
        forever begin
            advance(FRAME_CYCLES - 1);
            new_frame = 1'b1;
            advance(1);
            new_frame = 1'b0;
        end
    end

    always @(posedge clk_100) begin
        cycle_count <= cycle_count + 1;
        if (i_music_player.i_music_player_properties.error_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("test timed out after %0d cycles", cycle_count));
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        int since;
        arst_n      = 1'b0;
        play_button = 1'b0;
        next_button = 1'b0;
        repeat (10) @(posedge clk_100);
        #1 arst_n = 1'b1;
        // Idle frames before any press
        pause_random();
        advance(3 * FRAME_CYCLES);
        // Song 0 from idle to its end
        push_button(1'b0, since);
        catch_tone(first_note_cycles(0), since);
        watch_song_end(song_end_cycles(0), since);
        pause_random();
        // Next while idle selects song 1
        push_button(1'b1, since);
        pause_random();
        // Song 1, then pause for a while
        push_button(1'b0, since);
        catch_tone(first_note_cycles(1), since);
        push_button(1'b0, since);
        advance(QUIET_FRAMES * FRAME_CYCLES);
        // Next in pause, resume, next while playing
        push_button(1'b1, since);
        pause_random();
        push_button(1'b0, since);
        pause_random();
        push_button(1'b1, since);
        watch_song_end(song_end_cycles(1), since);
        advance(QUIET_FRAMES * FRAME_CYCLES);
        if (i_music_player.i_music_player_properties.error_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: list.f
verilog/music_pkg.sv
verilog/button_press_unit.sv
verilog/note_sequencer.sv
verilog/note_player.sv
verilog/sample_mixer.sv
verilog/music_player.sv
tests/music_player_properties.sv
tests/music_player_tb.sv
